// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_frame_split
RTL_TOP    := frame_split
FILELIST   := files.f
MDIR       := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(MDIR)
PASS_TEXT  := Simulation PASSED

.PHONY: all lint sim clean

all: sim

# lint the design top with the same file list
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# build and run, the pass line decides the exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(MDIR)

// File: dv/frame_model.svh
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

typedef byte_t byte_q_t[$];

localparam mac_addr_t  SRC_MAC = 48'h02_00_00_AA_BB_01;   // sender of every test frame
localparam ipv4_addr_t SRC_IP  = 32'hC0A8_0A63;

// folded one's-complement sum, an odd tail byte is padded with zero
function automatic csum_t ones_sum(input byte_q_t b, input int start, input int len,
                                   input logic [31:0] init);
    logic [31:0] s;
    byte_t       lo;
    int          i;
    s = init;
    for (i = 0; i < len; i += 2) begin
        lo = (i + 1 < len) ? b[start + i + 1] : 8'h00;
        s  = s + {16'h0, b[start + i], lo};
    end
    while (s[31:16] != 16'h0) begin
        s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
    end
    return s[15:0];
endfunction

function automatic logic [31:0] pseudo_sum(input ipv4_addr_t src, input ipv4_addr_t dst,
                                           input byte_t proto, input logic [15:0] ulen);
    return {16'h0, src[31:16]} + {16'h0, src[15:0]} + {16'h0, dst[31:16]}
         + {16'h0, dst[15:0]} + {24'h0, proto} + {16'h0, ulen};
endfunction

function automatic byte_q_t eth_header(input mac_addr_t dst, input logic [15:0] etype);
    logic [111:0] hdr;
    byte_q_t      q;
    int           i;
    hdr = {dst, SRC_MAC, etype};
    for (i = 13; i >= 0; i--) begin
        q.push_back(hdr[8*i +: 8]);
    end
    return q;
endfunction

function automatic byte_q_t arp_frame(input mac_addr_t dst, input byte_q_t body);
    byte_q_t q;
    int      i;
    q = eth_header(dst, ETHERTYPE_ARP);
    for (i = 0; i < body.size(); i++) begin
        q.push_back(body[i]);
    end
    return q;
endfunction

// full IPv4/UDP frame with both checksums filled in, zero padded to min_len
function automatic byte_q_t udp_frame(input mac_addr_t dst_mac, input ipv4_addr_t dst_ip,
                                      input byte_t ver_ihl, input byte_t proto,
                                      input byte_q_t pay, input int min_len);
    byte_q_t      f;
    logic [159:0] iph;
    logic [63:0]  udph;
    logic [15:0]  ulen;
    csum_t        c;
    int           i;
    ulen = 16'(pay.size() + UDP_HDR_BYTES);
    iph  = {ver_ihl, 8'h00, ulen + 16'(IP_HDR_BYTES), 16'h1C46, 16'h4000, 8'h40, proto,
            16'h0000, SRC_IP, dst_ip};
    udph = {16'd5353, 16'd7000, ulen, 16'h0000};
    f = eth_header(dst_mac, ETHERTYPE_IPV4);
    for (i = 19; i >= 0; i--) begin
        f.push_back(iph[8*i +: 8]);
    end
    c     = ~ones_sum(f, 14, 20, 32'h0);
    f[24] = c[15:8];
    f[25] = c[7:0];
    for (i = 7; i >= 0; i--) begin
        f.push_back(udph[8*i +: 8]);
    end
    for (i = 0; i < pay.size(); i++) begin
        f.push_back(pay[i]);
    end
    c     = ~ones_sum(f, 34, int'(ulen), pseudo_sum(SRC_IP, dst_ip, proto, ulen));
    f[40] = c[15:8];
    f[41] = c[7:0];
    while (f.size() < min_len) begin
        f.push_back(8'h00);                     // ethernet padding
    end
    return f;
endfunction

// expected bytes on each output port for one whole input frame
function automatic void expect_frame(input byte_q_t f, input mac_addr_t my_mac,
                                     input ipv4_addr_t my_ip, input int max_pay,
                                     output byte_q_t arp_exp, output byte_q_t udp_exp);
    mac_addr_t   dst;
    ipv4_addr_t  src_ip;
    logic [15:0] etype;
    logic [15:0] ulen;
    int          n;
    int          i;
    arp_exp.delete();
    udp_exp.delete();
    n = f.size();
    if (n <= ETH_HDR_BYTES) return;
    dst   = {f[0], f[1], f[2], f[3], f[4], f[5]};
    etype = {f[12], f[13]};
    if (dst != my_mac && dst != BROADCAST_MAC) return;
    if (etype == ETHERTYPE_ARP) begin
        for (i = ETH_HDR_BYTES; i < n; i++) begin
            arp_exp.push_back(f[i]);
        end
        return;
    end
    if (etype != ETHERTYPE_IPV4 || n <= 42) return;
    if (f[14] != IP_VER_IHL || {f[30], f[31], f[32], f[33]} != my_ip) return;
    if (ones_sum(f, 14, 20, 32'h0) != CSUM_GOOD || f[23] != IP_PROTO_UDP) return;
    src_ip = {f[26], f[27], f[28], f[29]};
    ulen   = {f[38], f[39]};
    if (ulen <= 16'd8 || int'(ulen) - 8 > max_pay || n < 34 + int'(ulen)) return;
    if (ones_sum(f, 34, int'(ulen), pseudo_sum(src_ip, my_ip, IP_PROTO_UDP, ulen))
        != CSUM_GOOD) return;
    for (i = 42; i < 34 + int'(ulen); i++) begin
        udp_exp.push_back(f[i]);                // padding stays behind
    end
endfunction

`endif

// File: dv/tb_frame_split.sv
`timescale 1ns/10ps

module tb_frame_split import frame_split_pkg::*; ();

    localparam mac_addr_t  LOCAL_MAC  = 48'h02_1A_2B_3C_4D_5E;
    localparam mac_addr_t  OTHER_MAC  = 48'h02_1A_2B_3C_4D_77;
    localparam ipv4_addr_t LOCAL_IP   = 32'hC0A8_0A02;
    localparam ipv4_addr_t OTHER_IP   = 32'hC0A8_0A03;
    localparam int         FIFO_DEPTH = 2048;

    `include "frame_model.svh"

    logic      logic_clk;
    logic      logic_rst;
    net_beat_t net_i;
    logic      net_valid_i;
    logic      net_ready_o;
    net_beat_t arp_o;
    logic      arp_valid_o;
    logic      arp_ready_i;
    net_beat_t udp_o;
    logic      udp_valid_o;
    logic      udp_ready_i;

    integer    seed;
    net_beat_t stim_q[$];
    net_beat_t exp_arp_q[$];
    net_beat_t exp_udp_q[$];
    int        mismatches = 0;
    int        unexpected = 0;
    int        missing    = 0;
    int        cycles     = 0;
    int        limit      = 1000;

    frame_split #(
        .LOCAL_MAC  (LOCAL_MAC),
        .LOCAL_IP   (LOCAL_IP),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .logic_clk   (logic_clk),
        .logic_rst   (logic_rst),
        .net_i       (net_i),
        .net_valid_i (net_valid_i),
        .net_ready_o (net_ready_o),
        .arp_o       (arp_o),
        .arp_valid_o (arp_valid_o),
        .arp_ready_i (arp_ready_i),
        .udp_o       (udp_o),
        .udp_valid_o (udp_valid_o),
        .udp_ready_i (udp_ready_i)
    );

    initial begin
        logic_clk = 1'b0;
        forever #50 logic_clk = !logic_clk;
    end

    function automatic byte_q_t random_bytes(input int n);
        byte_q_t q;
        int      i;
        for (i = 0; i < n; i++) begin
            q.push_back(byte_t'($random(seed)));
        end
        return q;
    endfunction

    // well formed datagram for this station
    function automatic byte_q_t local_udp(input int n, input int min_len);
        return udp_frame(LOCAL_MAC, LOCAL_IP, IP_VER_IHL, IP_PROTO_UDP, random_bytes(n), min_len);
    endfunction

    // queue the frame for sending and its expected output bytes
    task automatic add_frame(input byte_q_t f);
        byte_q_t arp_exp;
        byte_q_t udp_exp;
        int      i;
        expect_frame(f, LOCAL_MAC, LOCAL_IP, FIFO_DEPTH, arp_exp, udp_exp);
        for (i = 0; i < f.size(); i++) begin
            stim_q.push_back(net_beat_t'{data: f[i], last: i == f.size() - 1});
        end
        for (i = 0; i < arp_exp.size(); i++) begin
            exp_arp_q.push_back(net_beat_t'{data: arp_exp[i], last: i == arp_exp.size() - 1});
        end
        for (i = 0; i < udp_exp.size(); i++) begin
            exp_udp_q.push_back(net_beat_t'{data: udp_exp[i], last: i == udp_exp.size() - 1});
        end
    endtask

    task automatic random_ready();
        arp_ready_i <= ($random(seed) & 1) != 0;
        udp_ready_i <= ($random(seed) & 3) != 0;
    endtask

    task automatic compare_beat(input string port, input net_beat_t got, input net_beat_t exp);
        if (got.data !== exp.data || got.last !== exp.last) begin
            mismatches++;
            $display("mismatch at %0t: %s port gave data %02h last %0b, expected %02h last %0b",
                     $time, port, got.data, got.last, exp.data, exp.last);
        end
    endtask

    task automatic report_leftovers();
        if (exp_arp_q.size() != 0) begin
            missing += exp_arp_q.size();
            $display("ARP port never delivered %0d expected bytes", exp_arp_q.size());
        end
        if (exp_udp_q.size() != 0) begin
            missing += exp_udp_q.size();
            $display("UDP port never delivered %0d expected bytes", exp_udp_q.size());
        end
    endtask

    task automatic print_counts();
        $display("error counts: %0d mismatches, %0d unexpected bytes, %0d missing bytes",
                 mismatches, unexpected, missing);
    endtask

    // every output handshake pops one expected beat
    always @(posedge logic_clk) begin
        if (arp_valid_o && arp_ready_i) begin
            if (exp_arp_q.size() == 0) begin
                unexpected++;
                $display("ARP port delivered byte %02h that no frame should produce", arp_o.data);
            end else begin
                compare_beat("ARP", arp_o, exp_arp_q.pop_front());
            end
        end
        if (udp_valid_o && udp_ready_i) begin
            if (exp_udp_q.size() == 0) begin
                unexpected++;
                $display("UDP port delivered byte %02h that no frame should produce", udp_o.data);
            end else begin
                compare_beat("UDP", udp_o, exp_udp_q.pop_front());
            end
        end
    end

    always @(posedge logic_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            report_leftovers();
            print_counts();
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        byte_q_t f;
        byte_q_t pay;
        int      sent;
        int      k;
        seed        = 32'h500faf95;
        logic_rst   = 1'b1;
        net_i       = '0;
        net_valid_i = 1'b0;
        arp_ready_i = 1'b0;
        udp_ready_i = 1'b0;
        sent        = 0;

        add_frame(arp_frame(LOCAL_MAC, random_bytes(28)));
        add_frame(arp_frame(BROADCAST_MAC, random_bytes(46)));
        add_frame(local_udp(17, 0));                        // odd payload
        add_frame(local_udp(64, 0));
        f = local_udp(33, 0);
        f[50] = f[50] ^ 8'h04;                              // flipped payload bit
        add_frame(f);
        add_frame(local_udp(21, 0));
        f = local_udp(40, 0);
        f[41] = ~f[41];                                     // bad UDP checksum
        add_frame(f);
        add_frame(local_udp(8, 0));
        add_frame(udp_frame(OTHER_MAC, LOCAL_IP, IP_VER_IHL, IP_PROTO_UDP, random_bytes(12), 0));
        f = local_udp(12, 0);
        f[12] = 8'h86;                                      // IPv6 ethertype
        f[13] = 8'hDD;
        add_frame(f);
        add_frame(udp_frame(LOCAL_MAC, LOCAL_IP, 8'h46, IP_PROTO_UDP, random_bytes(12), 0));
        add_frame(udp_frame(LOCAL_MAC, OTHER_IP, IP_VER_IHL, IP_PROTO_UDP, random_bytes(12), 0));
        f = local_udp(12, 0);
        f[25] = f[25] ^ 8'h80;                              // bad IP header checksum
        add_frame(f);
        add_frame(udp_frame(LOCAL_MAC, LOCAL_IP, IP_VER_IHL, 8'h01, random_bytes(12), 0));
        add_frame(local_udp(1, 60));                        // padding drained
        pay = random_bytes(30);
        for (k = 0; k < 10; k++) begin
            pay.push_back(8'h00);                           // truncated frame still sums good
        end
        f = udp_frame(LOCAL_MAC, LOCAL_IP, IP_VER_IHL, IP_PROTO_UDP, pay, 0);
        for (k = 0; k < 10; k++) begin
            void'(f.pop_back());                            // ends inside the payload
        end
        add_frame(f);
        for (k = 0; k < 16; k++) begin
            if (($random(seed) & 3) == 0) begin
                add_frame(arp_frame(LOCAL_MAC, random_bytes(28 + ($random(seed) & 15))));
            end else begin
                add_frame(local_udp(1 + ($random(seed) & 127), 60));
            end
        end
        limit = 8 * stim_q.size() + 1000;

        repeat (4) @(posedge logic_clk);
        logic_rst <= 1'b0;

        while (sent < stim_q.size()) begin
            @(posedge logic_clk);
            random_ready();
            if (net_valid_i && net_ready_o) begin
                sent++;
            end
            if (!net_valid_i || net_ready_o) begin
                if (sent < stim_q.size() && ($random(seed) & 3) != 0) begin
                    net_i       <= stim_q[sent];
                    net_valid_i <= 1'b1;
                end else begin
                    net_valid_i <= 1'b0;            // idle gap
                end
            end
        end

        while (exp_arp_q.size() != 0 || exp_udp_q.size() != 0) begin
            @(posedge logic_clk);
            random_ready();
        end
        arp_ready_i <= 1'b1;
        udp_ready_i <= 1'b1;
        repeat (50) @(posedge logic_clk);                  // catch stray output

        report_leftovers();
        print_counts();
        if (mismatches + unexpected + missing == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+dv
hdl/frame_split_pkg.sv
hdl/ones_complement_sum.sv
hdl/udp_packet_fifo.sv
hdl/rx_header_parser.sv
hdl/frame_split.sv
dv/tb_frame_split.sv

// File: hdl/frame_split.sv
`timescale 1ns/10ps

module frame_split import frame_split_pkg::*; #(
    parameter mac_addr_t  LOCAL_MAC  = 48'hABCD_1234_5678,
    parameter ipv4_addr_t LOCAL_IP   = 32'hC0A8_006E,
    parameter int         FIFO_DEPTH = 2048
) (
    input  logic      logic_clk,
    input  logic      logic_rst,
    input  net_beat_t net_i,
    input  logic      net_valid_i,
    output logic      net_ready_o,
    output net_beat_t arp_o,
    output logic      arp_valid_o,
    input  logic      arp_ready_i,
    output net_beat_t udp_o,
    output logic      udp_valid_o,
    input  logic      udp_ready_i
);

    csum_t     ip_sum;
    logic      ip_clear;
    logic      ip_byte_valid;
    byte_t     ip_byte;
    csum_t     udp_sum;
    logic      udp_clear;
    logic      udp_byte_valid;
    byte_t     udp_byte;
    logic      udp_word_valid;
    csum_t     udp_word;
    net_beat_t fifo_wr;
    logic      fifo_wr_valid;
    logic      fifo_wr_ready;
    logic      fifo_commit;
    logic      fifo_drop;

    rx_header_parser #(
        .LOCAL_MAC  (LOCAL_MAC),
        .LOCAL_IP   (LOCAL_IP),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_parser (
        .logic_clk        (logic_clk),
        .logic_rst        (logic_rst),
        .net_i            (net_i),
        .net_valid_i      (net_valid_i),
        .net_ready_o      (net_ready_o),
        .arp_o            (arp_o),
        .arp_valid_o      (arp_valid_o),
        .arp_ready_i      (arp_ready_i),
        .ip_sum_i         (ip_sum),
        .ip_clear_o       (ip_clear),
        .ip_byte_valid_o  (ip_byte_valid),
        .ip_byte_o        (ip_byte),
        .udp_sum_i        (udp_sum),
        .udp_clear_o      (udp_clear),
        .udp_byte_valid_o (udp_byte_valid),
        .udp_byte_o       (udp_byte),
        .udp_word_valid_o (udp_word_valid),
        .udp_word_o       (udp_word),
        .fifo_wr_o        (fifo_wr),
        .fifo_wr_valid_o  (fifo_wr_valid),
        .fifo_wr_ready_i  (fifo_wr_ready),
        .fifo_commit_o    (fifo_commit),
        .fifo_drop_o      (fifo_drop)
    );

    // IP header sum is fed bytes only
    ones_complement_sum u_ip_sum (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .clear_i      (ip_clear),
        .byte_valid_i (ip_byte_valid),
        .byte_i       (ip_byte),
        .word_valid_i (1'b0),
        .word_i       ('0),
        .sum_o        (ip_sum)
    );

    ones_complement_sum u_udp_sum (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .clear_i      (udp_clear),
        .byte_valid_i (udp_byte_valid),
        .byte_i       (udp_byte),
        .word_valid_i (udp_word_valid),       // pseudo header
        .word_i       (udp_word),
        .sum_o        (udp_sum)
    );

    udp_packet_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .wr_i       (fifo_wr),
        .wr_valid_i (fifo_wr_valid),
        .wr_ready_o (fifo_wr_ready),
        .commit_i   (fifo_commit),
        .drop_i     (fifo_drop),
        .rd_o       (udp_o),
        .rd_valid_o (udp_valid_o),
        .rd_ready_i (udp_ready_i)
    );

endmodule

// File: hdl/frame_split_pkg.sv
package frame_split_pkg;

    // one byte of the stream
    typedef logic [7:0] byte_t;

    // stream beat shared by the input, the ARP port, the FIFO and the UDP port
    typedef struct packed {
        byte_t data;
        logic  last;                            // final byte of frame or datagram
    } net_beat_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] csum_t;

    // header sizes in bytes
    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES  = 20;          // no options
    localparam int UDP_HDR_BYTES = 8;

    // ethertypes
    localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    // IPv4 fields
    localparam byte_t IP_VER_IHL   = 8'h45;     // version 4, five words
    localparam byte_t IP_PROTO_UDP = 8'h11;

    localparam mac_addr_t BROADCAST_MAC = '1;

    // folded sum over a correct header or datagram, checksum field included
    localparam csum_t CSUM_GOOD = 16'hFFFF;

endpackage

// File: hdl/ones_complement_sum.sv
`timescale 1ns/10ps

module ones_complement_sum import frame_split_pkg::*; (
    input  logic  logic_clk,
    input  logic  logic_rst,
    input  logic  clear_i,
    input  logic  byte_valid_i,
    input  byte_t byte_i,
    input  logic  word_valid_i,
    input  csum_t word_i,
    output csum_t sum_o
);

    csum_t acc_q;                               // folded running sum
    byte_t hi_q;                                // high half waiting for its partner
    logic  hi_valid_q;
    csum_t in_word;
    csum_t pair_word;
    csum_t acc_nx;

    // 16-bit add with the end-around carry folded back in
    function automatic csum_t add_1c(input csum_t a, input csum_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + csum_t'(s[16]);
    endfunction

    always_comb begin
        in_word   = '0;
        pair_word = '0;
        if (word_valid_i) begin
            in_word = word_i;
        end
        if (byte_valid_i && hi_valid_q) begin
            pair_word = {hi_q, byte_i};         // high byte first
        end
        acc_nx = add_1c(acc_q, in_word);
        acc_nx = add_1c(acc_nx, pair_word);
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            acc_q      <= '0;
            hi_valid_q <= 1'b0;
        end else if (clear_i) begin
            acc_q      <= '0;
            hi_valid_q <= 1'b0;
        end else begin
            acc_q <= acc_nx;
            if (byte_valid_i) begin
                hi_valid_q <= !hi_valid_q;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (byte_valid_i && !hi_valid_q) begin
            hi_q <= byte_i;
        end
    end

    // an odd trailing byte counts as high half, zero padded
    assign sum_o = hi_valid_q ? add_1c(acc_q, {hi_q, 8'h00}) : acc_q;

endmodule

// File: hdl/rx_header_parser.sv
`timescale 1ns/10ps

module rx_header_parser import frame_split_pkg::*; #(
    parameter mac_addr_t  LOCAL_MAC  = 48'hABCD_1234_5678,
    parameter ipv4_addr_t LOCAL_IP   = 32'hC0A8_006E,
    parameter int         FIFO_DEPTH = 2048
) (
    input  logic      logic_clk,
    input  logic      logic_rst,
    input  net_beat_t net_i,
    input  logic      net_valid_i,
    output logic      net_ready_o,
    output net_beat_t arp_o,
    output logic      arp_valid_o,
    input  logic      arp_ready_i,
    input  csum_t     ip_sum_i,
    output logic      ip_clear_o,
    output logic      ip_byte_valid_o,
    output byte_t     ip_byte_o,
    input  csum_t     udp_sum_i,
    output logic      udp_clear_o,
    output logic      udp_byte_valid_o,
    output byte_t     udp_byte_o,
    output logic      udp_word_valid_o,
    output csum_t     udp_word_o,
    output net_beat_t fifo_wr_o,
    output logic      fifo_wr_valid_o,
    input  logic      fifo_wr_ready_i,
    output logic      fifo_commit_o,
    output logic      fifo_drop_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_ETH_HDR, S_ARP_FWD, S_IP_HDR, S_UDP_HDR, S_UDP_PAY, S_UDP_CHK, S_DRAIN
    } state_t;

    state_t      state_q;
    state_t      state_nx;
    logic [15:0] cnt_q;                         // accepted bytes in current section
    logic [15:0] pay_len_q;
    logic [15:0] udp_len_q;
    mac_addr_t   dst_mac_q;
    byte_t       type_hi_q;
    byte_t       ver_ihl_q;
    byte_t       proto_q;
    ipv4_addr_t  src_ip_q;
    ipv4_addr_t  dst_ip_q;
    logic        frame_end_q;                   // last seen with the final payload byte
    logic        short_q;                       // last came before the payload ended
    net_beat_t   arp_q;
    logic        arp_valid_q;

    logic        net_acc;
    logic [15:0] eth_type;
    logic        mac_ok;
    logic        ip_ok;
    logic        len_ok;
    logic        pay_done;

    always_comb begin
        case (state_q)
            S_ETH_HDR, S_IP_HDR, S_UDP_HDR, S_DRAIN: net_ready_o = 1'b1;
            S_ARP_FWD: net_ready_o = !arp_valid_q || arp_ready_i;  // slot free or leaving
            S_UDP_PAY: net_ready_o = fifo_wr_ready_i;
            default:   net_ready_o = 1'b0;
        endcase
    end

    assign net_acc  = net_valid_i && net_ready_o;
    assign eth_type = {type_hi_q, net_i.data};
    assign mac_ok   = (dst_mac_q == LOCAL_MAC) || (dst_mac_q == BROADCAST_MAC);
    assign pay_done = (cnt_q == pay_len_q - 16'd1);

    // IP verdict, ip_sum is complete from the first UDP header cycle on
    assign ip_ok = (ver_ihl_q == IP_VER_IHL) && (dst_ip_q == LOCAL_IP)
                && (ip_sum_i == CSUM_GOOD) && (proto_q == IP_PROTO_UDP);

    // needs a payload and must fit the FIFO
    assign len_ok = (udp_len_q > 16'(UDP_HDR_BYTES))
                 && (32'(udp_len_q) <= 32'(FIFO_DEPTH + UDP_HDR_BYTES));

    always_comb begin
        state_nx = state_q;
        case (state_q)
            S_IDLE: state_nx = S_ETH_HDR;       // sums cleared here
            S_ETH_HDR: begin
                if (net_acc && net_i.last) begin
                    state_nx = S_IDLE;          // runt
                end else if (net_acc && cnt_q == 16'(ETH_HDR_BYTES - 1)) begin
                    if (!mac_ok) begin
                        state_nx = S_DRAIN;
                    end else if (eth_type == ETHERTYPE_ARP) begin
                        state_nx = S_ARP_FWD;
                    end else if (eth_type == ETHERTYPE_IPV4) begin
                        state_nx = S_IP_HDR;
                    end else begin
                        state_nx = S_DRAIN;
                    end
                end
            end
            S_ARP_FWD: begin
                if (net_acc && net_i.last) begin
                    state_nx = S_IDLE;
                end
            end
            S_IP_HDR: begin
                if (net_acc && net_i.last) begin
                    state_nx = S_IDLE;
                end else if (net_acc && cnt_q == 16'(IP_HDR_BYTES - 1)) begin
                    state_nx = S_UDP_HDR;
                end
            end
            S_UDP_HDR: begin
                if (!ip_ok) begin
                    state_nx = (net_acc && net_i.last) ? S_IDLE : S_DRAIN;
                end else if (net_acc && net_i.last) begin
                    state_nx = S_IDLE;
                end else if (net_acc && cnt_q == 16'(UDP_HDR_BYTES - 1)) begin
                    state_nx = len_ok ? S_UDP_PAY : S_DRAIN;
                end
            end
            S_UDP_PAY: begin
                if (net_acc && (pay_done || net_i.last)) begin
                    state_nx = S_UDP_CHK;
                end
            end
            S_UDP_CHK: state_nx = frame_end_q ? S_IDLE : S_DRAIN;  // padding left over
            default: begin
                if (net_acc && net_i.last) begin
                    state_nx = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            state_q     <= S_IDLE;
            cnt_q       <= '0;
            arp_valid_q <= 1'b0;
            frame_end_q <= 1'b0;
            short_q     <= 1'b0;
        end else begin
            state_q <= state_nx;
            if (state_nx != state_q) begin
                cnt_q <= '0;
            end else if (net_acc) begin
                cnt_q <= cnt_q + 16'd1;
            end
            if (state_q == S_ARP_FWD && net_acc) begin
                arp_valid_q <= 1'b1;
            end else if (arp_ready_i) begin
                arp_valid_q <= 1'b0;
            end
            if (state_q == S_UDP_PAY && net_acc) begin
                frame_end_q <= net_i.last;
                short_q     <= net_i.last && !pay_done;
            end
        end
    end

    // field capture, big endian shifts
    always_ff @(posedge logic_clk) begin
        if (net_acc) begin
            case (state_q)
                S_ETH_HDR: begin
                    if (cnt_q < 16'd6) begin
                        dst_mac_q <= {dst_mac_q[39:0], net_i.data};
                    end
                    if (cnt_q == 16'd12) begin
                        type_hi_q <= net_i.data;
                    end
                end
                S_IP_HDR: begin
                    if (cnt_q == 16'd0) begin
                        ver_ihl_q <= net_i.data;
                    end
                    if (cnt_q == 16'd9) begin
                        proto_q <= net_i.data;
                    end
                    if (cnt_q >= 16'd12 && cnt_q < 16'd16) begin
                        src_ip_q <= {src_ip_q[23:0], net_i.data};
                    end
                    if (cnt_q >= 16'd16) begin
                        dst_ip_q <= {dst_ip_q[23:0], net_i.data};
                    end
                end
                S_UDP_HDR: begin
                    if (cnt_q == 16'd4 || cnt_q == 16'd5) begin
                        udp_len_q <= {udp_len_q[7:0], net_i.data};
                    end
                    if (cnt_q == 16'(UDP_HDR_BYTES - 1)) begin
                        pay_len_q <= udp_len_q - 16'(UDP_HDR_BYTES);
                    end
                end
                S_ARP_FWD: arp_q <= net_i;
                default: ;
            endcase
        end
    end

    assign arp_o       = arp_q;
    assign arp_valid_o = arp_valid_q;

    assign ip_clear_o      = (state_q == S_IDLE);
    assign ip_byte_valid_o = net_acc && (state_q == S_IP_HDR);
    assign ip_byte_o       = net_i.data;

    assign udp_clear_o      = (state_q == S_IDLE);
    assign udp_byte_valid_o = net_acc && (state_q == S_UDP_HDR || state_q == S_UDP_PAY);
    assign udp_byte_o       = net_i.data;
    assign udp_word_valid_o = net_acc && (state_q == S_UDP_HDR) && (cnt_q < 16'd6);

    // pseudo header, one word per UDP header beat
    always_comb begin
        case (cnt_q[2:0])
            3'd0:    udp_word_o = src_ip_q[31:16];
            3'd1:    udp_word_o = src_ip_q[15:0];
            3'd2:    udp_word_o = dst_ip_q[31:16];
            3'd3:    udp_word_o = dst_ip_q[15:0];
            3'd4:    udp_word_o = {8'h00, proto_q};
            default: udp_word_o = {udp_len_q[7:0], net_i.data};  // length hi from beat 4
        endcase
    end

    assign fifo_wr_o       = '{data: net_i.data, last: pay_done};
    assign fifo_wr_valid_o = net_valid_i && (state_q == S_UDP_PAY);
    assign fifo_commit_o   = (state_q == S_UDP_CHK) && (udp_sum_i == CSUM_GOOD) && !short_q;
    assign fifo_drop_o     = (state_q == S_UDP_CHK) && !fifo_commit_o;

endmodule

// File: hdl/udp_packet_fifo.sv
`timescale 1ns/10ps

module udp_packet_fifo import frame_split_pkg::*; #(
    parameter int FIFO_DEPTH = 2048            // power of two
) (
    input  logic      logic_clk,
    input  logic      logic_rst,
    input  net_beat_t wr_i,
    input  logic      wr_valid_i,
    output logic      wr_ready_o,
    input  logic      commit_i,
    input  logic      drop_i,
    output net_beat_t rd_o,
    output logic      rd_valid_o,
    input  logic      rd_ready_i
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // one extra bit tells full from empty
    typedef logic [AW:0] ptr_t;

    net_beat_t mem [FIFO_DEPTH];

    ptr_t wr_ptr_q;                             // next free entry, uncommitted data below
    ptr_t cm_ptr_q;                             // end of committed data
    ptr_t rd_ptr_q;
    ptr_t used;
    logic wr_fire;
    logic rd_fire;

    // space is only freed by the reader
    assign used       = wr_ptr_q - rd_ptr_q;
    assign wr_ready_o = (used != ptr_t'(FIFO_DEPTH));
    assign wr_fire    = wr_valid_i && wr_ready_o;

    // reader only sees committed beats
    assign rd_valid_o = (rd_ptr_q != cm_ptr_q);
    assign rd_o       = mem[rd_ptr_q[AW-1:0]];
    assign rd_fire    = rd_valid_o && rd_ready_i;

    always_ff @(posedge logic_clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q[AW-1:0]] <= wr_i;
        end
    end

    // write side, rollback wins over a stray write
    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            wr_ptr_q <= '0;
        end else if (drop_i) begin
            wr_ptr_q <= cm_ptr_q;               // forget the partial datagram
        end else if (wr_fire) begin
            wr_ptr_q <= wr_ptr_q + ptr_t'(1);
        end
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            cm_ptr_q <= '0;
        end else if (commit_i) begin
            cm_ptr_q <= wr_ptr_q;               // datagram becomes readable
        end
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            rd_ptr_q <= '0;
        end else if (rd_fire) begin
            rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
    end

endmodule
